//--- ppu.f
design/ppu_pkg.sv
design/ppu_op_pkg.sv
design/posit_decoder.sv
design/posit_encoder.sv
design/ppu_core_ops.sv
design/ppu_control_unit.sv
design/ppu.sv
sim/ppu_asserts.sv
sim/ppu_tb.sv

//--- Bender.yml
package:
  name: ppu

sources:
  # packages first, then leaf modules, then the top level
  - files:
      - design/ppu_pkg.sv
      - design/ppu_op_pkg.sv
      - design/posit_decoder.sv
      - design/posit_encoder.sv
      - design/ppu_core_ops.sv
      - design/ppu_control_unit.sv
      - design/ppu.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - sim/ppu_asserts.sv
      - sim/ppu_tb.sv

//--- sim/ppu_tb.sv
// Self-checking testbench for ppu with posit16 es1; operands are driven zero-extended in the bus word.
`timescale 1ns/1ps

module ppu_tb;

  import ppu_pkg::*;
  import ppu_op_pkg::*;

  localparam int NUM_TESTS  = 21;
  localparam int BURST      = 8; // leading rows go in back to back
  localparam int LATENCY    = 3;
  localparam int RES_WAIT   = 20; // cycles allowed for the oldest pending result
  localparam int DRAIN_WAIT = 200;

  // each row holds {opcode, operand 1, operand 2, expected posit}
  localparam logic [49:0] TABLE [NUM_TESTS] = '{
    {ADD, 16'h4000, 16'h4000, 16'h5000}, // 1 + 1 = 2
    {ADD, 16'h4000, 16'hC000, 16'h0000}, // 1 + -1 cancels exactly
    {ADD, 16'h4000, 16'h0000, 16'h4000}, // zero passes the other operand through
    {SUB, 16'h5000, 16'h4000, 16'h4000}, // 2 - 1 = 1
    {SUB, 16'h4000, 16'h5000, 16'hC000}, // 1 - 2 = -1
    {MUL, 16'h5000, 16'h5000, 16'h6000}, // 2 * 2 = 4
    {MUL, 16'h5000, 16'hC000, 16'hB000}, // 2 * -1 = -2
    {MUL, 16'h4800, 16'h0000, 16'h0000}, // 1.5 * 0 = 0
    {ADD, 16'h8000, 16'h4000, 16'h8000}, // NaR propagates
    {SUB, 16'h4000, 16'h8000, 16'h8000},
    {MUL, 16'h8000, 16'h0000, 16'h8000}, // NaR wins over zero
    {MUL, 16'h7FFF, 16'h7FFF, 16'h7FFF}, // 2^56 clamps to maxpos
    {MUL, 16'h0001, 16'h0001, 16'h0001}, // 2^-56 clamps to minpos
    {ADD, 16'h4000, 16'h0001, 16'h4000}, // minpos lands far below the fraction LSB
    {ADD, 16'h4000, 16'h00C0, 16'h4000}, // 1 + 2^-13 is a tie that stays even
    {ADD, 16'h4000, 16'h0140, 16'h4002}, // 1 + 3*2^-13 is a tie that rounds up to even
    {ADD, 16'h4800, 16'h4800, 16'h5800}, // 1.5 + 1.5 = 3
    {MUL, 16'h4800, 16'h4800, 16'h5200}, // 1.5 * 1.5 = 2.25
    {ADD, 16'h0000, 16'h4000, 16'h4000},
    {MUL, 16'hC000, 16'hC000, 16'h4000}, // -1 * -1 = 1
    {MUL, 16'h7FFF, 16'h8001, 16'h8001}  // maxpos * -maxpos clamps to -maxpos
  };

  logic       clk_i;
  logic       reset_i;
  logic       in_valid_i;
  word_t      operand1_i;
  word_t      operand2_i;
  operation_e op_i;
  word_t      result_o;
  logic       out_valid_o;

  int cycle_count = 0;
  int issued      = 0;
  int checked     = 0;
  int pass_count  = 0;
  int fail_count  = 0;
  int stray_count = 0;
  bit timed_out   = 1'b0;
  int issue_q[$]; // cycle in which each in-flight operation was accepted
  int row_q[$];

  ppu ppu_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .operand1_i  (operand1_i),
    .operand2_i  (operand2_i),
    .op_i        (op_i),
    .result_o    (result_o),
    .out_valid_o (out_valid_o)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  function automatic string op_text(input logic [1:0] code);
    case (code)
      2'd0:    return "ADD";
      2'd1:    return "SUB";
      2'd2:    return "MUL";
      default: return "NOP";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp, output bit ok);
    ok = (got === exp);
    if (!ok) begin
      $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic score_result(input int row, input int latency);
    logic [49:0] entry;
    bit          ok_value;
    bit          ok_latency;
    entry = TABLE[row];
    check_value("result_o", result_o, {16'h0000, entry[15:0]}, ok_value);
    check_value("latency", 32'(latency), 32'(LATENCY), ok_latency);
    if (ok_value && ok_latency) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    $display("test %0d %s 0x%h 0x%h -> 0x%h %s", row, op_text(entry[49:48]),
             entry[47:32], entry[31:16], result_o[15:0],
             (ok_value && ok_latency) ? "ok" : "failed");
    checked++;
  endtask

  // results are matched in issue order and an empty queue means a duplicate or stray result
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (out_valid_o === 1'b1) begin
      if (row_q.size() == 0) begin
        $display("result 0x%h appeared with no operation in flight", result_o);
        stray_count++;
      end else begin
        score_result(row_q.pop_front(), cycle_count - issue_q.pop_front());
      end
    end else if (issue_q.size() != 0 && (cycle_count - issue_q[0]) > RES_WAIT) begin
      timed_out = 1'b1;
    end
    if (in_valid_i === 1'b1 && reset_i === 1'b0) begin
      issue_q.push_back(cycle_count);
      row_q.push_back(issued);
      issued++;
    end
  end

  initial begin
    int unsigned rng_seed;
    int unsigned first_draw;
    int          gap;
    int          wait_cycles;
    rng_seed   = 32'he4a;
    first_draw = $urandom(rng_seed);
    reset_i    = 1'b1;
    in_valid_i = 1'b0;
    operand1_i = '0;
    operand2_i = '0;
    op_i       = ADD;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;

    for (int i = 0; i < NUM_TESTS; i++) begin
      @(posedge clk_i);
      in_valid_i <= 1'b1;
      op_i       <= operation_e'(TABLE[i][49:48]);
      operand1_i <= {16'h0000, TABLE[i][47:32]};
      operand2_i <= {16'h0000, TABLE[i][31:16]};
      gap = (i < BURST) ? 0 : int'($urandom % 3);
      repeat (gap) begin
        @(posedge clk_i);
        in_valid_i <= 1'b0;
      end
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;

    wait_cycles = 0;
    while (checked < NUM_TESTS && !timed_out && wait_cycles < DRAIN_WAIT) begin
      @(negedge clk_i);
      wait_cycles++;
    end
    if (timed_out) begin
      $display("no result within timeout for test %0d", checked);
    end else if (checked < NUM_TESTS) begin
      $display("only %0d of %0d results arrived", checked, NUM_TESTS);
    end
    $display("tests %0d passed %0d failed %0d stray %0d", NUM_TESTS, pass_count,
             fail_count, stray_count);
    if (checked == NUM_TESTS && !timed_out && fail_count == 0 && stray_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : ppu_tb

//--- sim/ppu_asserts.sv
// Bound ppu checks; they assume a fixed latency of 3 and an N-bit posit in a 32-bit word.
`timescale 1ns/1ps

module ppu_asserts #(
  parameter int N = ppu_pkg::N_DEFAULT
) (
  input logic                                          clk_i,
  input logic                                          reset_i,
  input logic                                          in_valid_i,
  input logic                                          out_valid_i,
  input ppu_pkg::word_t                                result_i,
  input logic [$clog2(ppu_op_pkg::PIPE_DEPTH+1)-1:0]   inflight_i
);

  import ppu_pkg::*;

  localparam int LAT = 3; // edges from an accepted operation to its result

  reset_quiet: assert property (@(posedge clk_i) reset_i |=> !out_valid_i)
    else $error("out_valid_o high during or right after reset");

  result_follows: assert property (@(posedge clk_i) disable iff (reset_i)
    in_valid_i |-> ##LAT out_valid_i)
    else $error("accepted operation gave no result after the fixed latency");

  no_extra_result: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_i |-> $past(in_valid_i, LAT))
    else $error("result appeared without a matching operation");

  upper_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_i |-> (result_i[WORD-1:N] == '0))
    else $error("result_o upper bits are not zero");

  // the count covers every operation accepted in the last LAT cycles
  inflight_match: assert property (@(posedge clk_i) disable iff (reset_i)
    inflight_i == $countones({$past(in_valid_i, 1), $past(in_valid_i, 2),
                              $past(in_valid_i, LAT)}))
    else $error("in-flight count differs from the operations accepted recently");

endmodule : ppu_asserts

bind ppu ppu_asserts #(.N(N)) ppu_asserts_inst (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .in_valid_i  (in_valid_i),
  .out_valid_i (out_valid_o),
  .result_i    (result_o),
  .inflight_i  (ppu_control_unit_inst.inflight_q)
);

//--- design/ppu.sv
// Posit unit top; operands use the low N bits of each word, and result_o is zero-extended.
`timescale 1ns/1ps

module ppu #(
  parameter int N  = ppu_pkg::N_DEFAULT,
  parameter int ES = ppu_pkg::ES_DEFAULT
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   in_valid_i,
  input  ppu_pkg::word_t         operand1_i,
  input  ppu_pkg::word_t         operand2_i,
  input  ppu_op_pkg::operation_e op_i,
  output ppu_pkg::word_t         result_o,
  output logic                   out_valid_o
);

  import ppu_pkg::*;

  logic [N-1:0] p1;
  logic [N-1:0] p2;
  logic [N-1:0] posit;

  assign p1 = operand1_i[N-1:0];
  assign p2 = operand2_i[N-1:0];

  ppu_core_ops #(
    .N      (N),
    .ES     (ES)
  ) ppu_core_ops_inst (
    .clk_i  (clk_i),
    .p1_i   (p1),
    .p2_i   (p2),
    .op_i   (op_i),
    .pout_o (posit)
  );

  ppu_control_unit ppu_control_unit_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (in_valid_i),
    .valid_o (out_valid_o)
  );

  assign result_o = {{(WORD-N){1'b0}}, posit};

endmodule : ppu

//--- design/ppu_control_unit.sv
// Valid tracking for the fixed-latency pipeline; there is no back-pressure and no stall.
`timescale 1ns/1ps

module ppu_control_unit (
  input  logic clk_i,
  input  logic reset_i,
  input  logic valid_i,
  output logic valid_o
);

  import ppu_op_pkg::*;

  localparam int CW = $clog2(PIPE_DEPTH + 1);

  logic [PIPE_DEPTH-1:0] valid_q;
  logic [CW-1:0]         inflight_q; // operations currently inside the pipeline

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[PIPE_DEPTH-2:0], valid_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      inflight_q <= '0;
    end else begin
      inflight_q <= inflight_q + CW'(valid_i) - CW'(valid_q[PIPE_DEPTH-1]);
    end
  end

  assign valid_o = valid_q[PIPE_DEPTH-1];

endmodule : ppu_control_unit

//--- design/ppu_core_ops.sv
// Three-stage posit add, subtract and multiply with a fixed 3-cycle latency; data registers have no reset.
`timescale 1ns/1ps

module ppu_core_ops #(
  parameter int N  = 16,
  parameter int ES = 1
) (
  input  logic                   clk_i,
  input  logic [N-1:0]           p1_i,
  input  logic [N-1:0]           p2_i,
  input  ppu_op_pkg::operation_e op_i,
  output logic [N-1:0]           pout_o
);

  import ppu_pkg::*;
  import ppu_op_pkg::*;

  localparam int FW = N - ES;
  localparam int GB = FRAC_GUARD;
  localparam int SW = $clog2(N) + ES + 3;
  localparam int EW = FW + GB + 1; // aligned addend with carry bit on top
  localparam int AW = $clog2(EW) + 1;
  localparam int RW = 2 * FW; // raw result, 1.0 sits at bit RW-2
  localparam int LW = $clog2(RW) + 1;

  logic                 d1_sign, d2_sign, d1_zero, d2_zero, d1_nar, d2_nar;
  logic signed [SW-1:0] d1_scale, d2_scale;
  logic [FW-1:0]        d1_frac, d2_frac;

  logic                 s1_sign1, s1_sign2, s1_zero1, s1_zero2, s1_nar;
  logic signed [SW-1:0] s1_scale1, s1_scale2;
  logic [FW-1:0]        s1_frac1, s1_frac2;
  operation_e           s1_op;

  logic                 big_sel, big_sign, sm_zero, add_sticky;
  logic signed [SW-1:0] big_scale, sm_scale, scale_diff;
  logic [FW-1:0]        big_frac, sm_frac;
  logic [AW-1:0]        align_sh;
  logic [EW-1:0]        big_ext, sm_ext, aligned, sum;
  logic [2*EW-1:0]      sh_wide;
  logic [RW-1:0]        prod;
  logic                 res_sign, res_sticky, res_zero;
  logic signed [SW-1:0] res_scale;
  logic [RW-1:0]        res_raw;

  logic                 s2_sign, s2_sticky, s2_zero, s2_nar;
  logic signed [SW-1:0] s2_scale;
  logic [RW-1:0]        s2_raw;

  logic [LW-1:0]        lead_zeros;
  logic                 lead_found;
  logic [RW-1:0]        norm;
  logic signed [SW-1:0] enc_scale;
  logic                 enc_sticky;
  logic [N-1:0]         enc_bits;
  logic [N-1:0]         s3_pout;

  posit_decoder #(.N(N), .ES(ES)) dec1_inst (
    .bits_i (p1_i), .sign_o (d1_sign), .scale_o (d1_scale),
    .frac_o (d1_frac), .zero_o (d1_zero), .nar_o (d1_nar)
  );

  posit_decoder #(.N(N), .ES(ES)) dec2_inst (
    .bits_i (p2_i), .sign_o (d2_sign), .scale_o (d2_scale),
    .frac_o (d2_frac), .zero_o (d2_zero), .nar_o (d2_nar)
  );

  always_ff @(posedge clk_i) begin
    s1_sign1  <= d1_sign;
    s1_sign2  <= d2_sign ^ (op_i == SUB); // subtract is add of the negated operand
    s1_scale1 <= d1_scale;
    s1_scale2 <= d2_scale;
    s1_frac1  <= d1_frac;
    s1_frac2  <= d2_frac;
    s1_zero1  <= d1_zero;
    s1_zero2  <= d2_zero;
    s1_nar    <= d1_nar | d2_nar;
    s1_op     <= op_i;
  end

  // a zero operand is never picked as the larger one unless both are zero
  assign big_sel   = s1_zero2 | (~s1_zero1 & ((s1_scale1 > s1_scale2) |
                     ((s1_scale1 == s1_scale2) & (s1_frac1 >= s1_frac2))));
  assign big_sign  = big_sel ? s1_sign1 : s1_sign2;
  assign big_scale = big_sel ? s1_scale1 : s1_scale2;
  assign big_frac  = big_sel ? s1_frac1 : s1_frac2;
  assign sm_scale  = big_sel ? s1_scale2 : s1_scale1;
  assign sm_frac   = big_sel ? s1_frac2 : s1_frac1;
  assign sm_zero   = s1_zero1 | s1_zero2;

  assign scale_diff = big_scale - sm_scale;
  assign align_sh   = sm_zero ? '0 : ((scale_diff > EW) ? AW'(EW) : AW'(scale_diff));
  assign big_ext    = {1'b0, big_frac, {GB{1'b0}}};
  assign sm_ext     = sm_zero ? '0 : {1'b0, sm_frac, {GB{1'b0}}};
  assign sh_wide    = {sm_ext, {EW{1'b0}}} >> align_sh;
  assign aligned    = sh_wide[2*EW-1:EW];
  assign add_sticky = |sh_wide[EW-1:0];

  // the extra LSB keeps the difference below the exact value when bits were lost
  assign sum  = (s1_sign1 ^ s1_sign2) ? (big_ext - aligned - EW'(add_sticky))
                                      : (big_ext + aligned);
  assign prod = s1_frac1 * s1_frac2;

  always_comb begin
    case (s1_op)
      MUL: begin
        res_sign   = s1_sign1 ^ s1_sign2;
        res_scale  = s1_scale1 + s1_scale2;
        res_raw    = prod;
        res_sticky = 1'b0;
        res_zero   = s1_zero1 | s1_zero2;
      end
      NOP: begin
        res_sign   = 1'b0;
        res_scale  = '0;
        res_raw    = '0;
        res_sticky = 1'b0;
        res_zero   = 1'b1;
      end
      default: begin // add and subtract
        res_sign   = big_sign;
        res_scale  = big_scale;
        res_raw    = {sum, {(RW-EW){1'b0}}};
        res_sticky = add_sticky;
        res_zero   = s1_zero1 & s1_zero2;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    s2_sign   <= res_sign;
    s2_scale  <= res_scale;
    s2_raw    <= res_raw;
    s2_sticky <= res_sticky;
    s2_zero   <= res_zero;
    s2_nar    <= s1_nar;
  end

  always_comb begin
    lead_zeros = '0;
    lead_found = 1'b0;
    for (int i = RW - 1; i >= 0; i--) begin
      if (!lead_found && !s2_raw[i]) begin
        lead_zeros = lead_zeros + 1'b1;
      end else begin
        lead_found = 1'b1;
      end
    end
  end

  assign norm       = s2_raw << lead_zeros;
  assign enc_scale  = s2_scale + SW'(1) - SW'(lead_zeros); // leading one moves to RW-1
  assign enc_sticky = s2_sticky | (|norm[RW-FW-GB-1:0]);

  posit_encoder #(.N(N), .ES(ES)) enc_inst (
    .sign_i   (s2_sign),
    .scale_i  (enc_scale),
    .frac_i   (norm[RW-1 -: FW+GB]),
    .sticky_i (enc_sticky),
    .bits_o   (enc_bits)
  );

  always_ff @(posedge clk_i) begin
    if (s2_nar) begin
      s3_pout <= {1'b1, {(N-1){1'b0}}};
    end else if (s2_zero || (s2_raw == '0)) begin // exact cancellation also lands here
      s3_pout <= '0;
    end else begin
      s3_pout <= enc_bits;
    end
  end

  assign pout_o = s3_pout;

endmodule : ppu_core_ops

//--- design/posit_encoder.sv
// Combinational posit encoder; frac_i must be normalized (MSB set) and zero or NaR is handled outside.
`timescale 1ns/1ps

module posit_encoder #(
  parameter int N  = 16,
  parameter int ES = 1
) (
  input  logic                                sign_i,
  input  logic signed [$clog2(N)+ES+2:0]      scale_i,
  input  logic [N-ES+ppu_pkg::FRAC_GUARD-1:0] frac_i,
  input  logic                                sticky_i,
  output logic [N-1:0]                        bits_o
);

  import ppu_pkg::*;

  localparam int FW   = N - ES; // fraction with hidden bit
  localparam int GB   = FRAC_GUARD;
  localparam int SW   = $clog2(N) + ES + 3;
  localparam int TW   = ES + FW + GB - 1; // exponent plus fraction without hidden bit
  localparam int VW   = N + TW; // room for the longest regime plus the tail
  localparam int BW   = N - 1;
  localparam int RMAX = N - 2; // largest regime value that fits

  logic signed [SW-1:0] regime;
  logic                 reg_neg;
  logic [SW-1:0]        shamt;
  logic [VW-1:0]        seed;
  logic [VW-1:0]        shifted;
  logic [BW-1:0]        body;
  logic                 guard_bit;
  logic                 rest_sticky;
  logic                 round_up;
  logic [BW-1:0]        mag;
  logic [N-1:0]         pos;

  assign regime  = scale_i >>> ES; // floor division by 2^ES
  assign reg_neg = regime[SW-1];

  // A positive regime is a run of R+1 ones ended by a zero. A negative regime
  // is a run of -R zeros ended by a one. The arithmetic shift fills in the run.
  assign shamt = reg_neg ? ~regime : regime;
  assign seed  = {~reg_neg, reg_neg, scale_i[ES-1:0], frac_i[FW+GB-2:0],
                  {(N-2){1'b0}}};

  assign shifted = $signed(seed) >>> shamt;

  assign body        = shifted[VW-1 -: BW];
  assign guard_bit   = shifted[VW-N];
  assign rest_sticky = (|shifted[VW-N-1:0]) | sticky_i;

  // round to nearest even, maxpos never rounds up into NaR
  assign round_up = guard_bit & (rest_sticky | body[0]) & ~(&body);
  assign mag      = body + BW'(round_up);

  always_comb begin
    if (regime > RMAX) begin
      pos = {1'b0, {BW{1'b1}}}; // saturate to maxpos
    end else if (regime < -RMAX) begin
      pos = {{BW{1'b0}}, 1'b1}; // saturate to minpos
    end else begin
      pos = {1'b0, mag};
    end
  end

  assign bits_o = sign_i ? -pos : pos;

endmodule : posit_encoder

//--- design/posit_decoder.sv
// Combinational posit decoder; scale_o and frac_o are meaningless when zero_o or nar_o is set.
`timescale 1ns/1ps

module posit_decoder #(
  parameter int N  = 16,
  parameter int ES = 1
) (
  input  logic [N-1:0]                  bits_i,
  output logic                          sign_o,
  output logic signed [$clog2(N)+ES+2:0] scale_o,
  output logic [N-ES-1:0]               frac_o,
  output logic                          zero_o,
  output logic                          nar_o
);

  localparam int SW = $clog2(N) + ES + 3; // signed scale width
  localparam int KW = $clog2(N) + 1; // run length, wide enough to hold run + 1
  localparam int BW = N - 1; // body width without the sign bit

  logic [N-1:0]         abs_bits;
  logic [BW-1:0]        body;
  logic                 reg_bit;
  logic [KW-1:0]        run_len;
  logic                 run_done;
  logic [BW-1:0]        rem;
  logic [ES-1:0]        exp_bits;
  logic signed [SW-1:0] regime;

  assign zero_o = (bits_i == '0);
  assign nar_o  = (bits_i == {1'b1, {(N-1){1'b0}}});
  assign sign_o = bits_i[N-1];

  // negative posits are stored as two's complement of the magnitude
  assign abs_bits = sign_o ? -bits_i : bits_i;
  assign body     = abs_bits[N-2:0];
  assign reg_bit  = body[BW-1];

  // length of the run of identical bits at the top of the body
  always_comb begin
    run_len  = '0;
    run_done = 1'b0;
    for (int i = BW - 1; i >= 0; i--) begin
      if (!run_done && (body[i] == reg_bit)) begin
        run_len = run_len + 1'b1;
      end else begin
        run_done = 1'b1;
      end
    end
  end

  // drop the regime run and its terminating bit
  assign rem      = body << (run_len + 1'b1);
  assign exp_bits = rem[BW-1 -: ES];

  // a run of ones gives k-1, a run of zeros gives -k
  assign regime = reg_bit ? (SW'(run_len) - SW'(1)) : -SW'(run_len);

  assign scale_o = (regime <<< ES) + SW'(exp_bits);
  assign frac_o  = {1'b1, rem[BW-ES-1:0]}; // hidden bit on top

endmodule : posit_decoder

//--- design/ppu_op_pkg.sv
// Opcode encoding and fixed pipeline latency; opcode NOP yields a zero result.
package ppu_op_pkg;

  typedef enum logic [1:0] {
    ADD = 2'd0,
    SUB = 2'd1,
    MUL = 2'd2,
    NOP = 2'd3 // reserved
  } operation_e;

  // cycles from in_valid_i to out_valid_o, the same for every operation
  localparam int PIPE_DEPTH = 3;

endpackage : ppu_op_pkg

//--- design/ppu_pkg.sv
// Posit format defaults: the bus word is 32 bits and posits use only its low N bits.
package ppu_pkg;

  // width of one operand or result word on the bus
  localparam int WORD = 32;

  typedef logic [WORD-1:0] word_t;

  // default posit format, posit16 with one exponent bit
  localparam int N_DEFAULT  = 16;
  localparam int ES_DEFAULT = 1;

  // guard, round and sticky bits carried below the fraction LSB up to the encoder
  localparam int FRAC_GUARD = 3;

  // The top level passes N and ES down as parameters. Each module works out its
  // own widths from them:
  //   fraction with hidden bit  N - ES
  //   signed scale              $clog2(N) + ES + 3
  // The scale width covers the sum of two extreme scales plus the normalization
  // step of a product.

endpackage : ppu_pkg
